/* include/pwo_cfg.svh */
// Pointwise engine configuration constants for the ML-DSA field
`ifndef PWO_CFG_SVH
`define PWO_CFG_SVH

// Field modulus q = 2^23 - 2^13 + 1
`define PWO_Q 8380417

// Polynomial geometry
`define PWO_N 256
`define PWO_LANES 4
`define PWO_WORDS (`PWO_N / `PWO_LANES)

// Coefficient in a 24-bit lane slot, top bit padded with zero
`define PWO_COEFF_W 23
`define PWO_LANE_W 24

`define PWO_ADDR_W 15

// Latencies in clock cycles
`define PWO_RD_LAT 1
`define PWO_ALU_LAT 3
`define PWO_PIPE_LAT (`PWO_RD_LAT + `PWO_ALU_LAT)

`endif

/* pwo_top.f */
+incdir+include
verilog/pwo_pkg.sv
verilog/pwo_mode_regs.sv
verilog/pwo_addr_seq.sv
verilog/pwo_mod_alu.sv
verilog/pwo_delay_pipe.sv
verilog/pwo_top.sv
verification/pwo_checker.sv
verification/pwo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pointwise engine testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pwo_tb \
    -f pwo_top.f -Mdir obj_dir -o pwo_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/pwo_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* verification/pwo_checker.sv */
// Protocol assertions on the pointwise engine request and status outputs
`timescale 1ns/1ps
`default_nettype none

module pwo_checker (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  enable_i,
    input pwo_pkg::pwo_mode_e    mode_i,
    input logic                  accumulate_i,
    input pwo_pkg::pwo_mem_req_t rd_a_i,
    input pwo_pkg::pwo_mem_req_t rd_b_i,
    input pwo_pkg::pwo_mem_req_t rd_c_i,
    input pwo_pkg::pwo_mem_req_t wr_i,
    input logic                  busy_i,
    input logic                  done_i
);

    // Failed assertion count
    int fail_count = 0;

    // Host setup of the current run, taken at the first enable while idle
    pwo_pkg::pwo_mode_e run_mode_q;
    logic               run_acc_q;
    logic               armed_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run_mode_q <= pwo_pkg::PWO_PWM;
            run_acc_q  <= 1'b0;
            armed_q    <= 1'b0;
        end
        else if (enable_i && !busy_i && !armed_q) begin
            run_mode_q <= mode_i;
            run_acc_q  <= accumulate_i;
            armed_q    <= 1'b1;
        end
        else if (busy_i) begin
            armed_q <= 1'b0;
        end
    end

    // Requests only inside a run
    a_req_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_a_i.en || rd_b_i.en || rd_c_i.en || wr_i.en) |-> busy_i)
        else begin
            fail_count++;
            $error("request enable seen while busy_o is low");
        end

    //========================================
    // Done pulse
    //========================================
    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            fail_count++;
            $error("done_o held longer than one cycle");
        end

    a_done_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> (!busy_i && $past(busy_i)))
        else begin
            fail_count++;
            $error("done_o not aligned with the fall of busy_o");
        end

    // Old c only for an accumulating multiply
    a_c_read: assert property (@(posedge clk) disable iff (!reset_n)
        rd_c_i.en |-> ((run_mode_q == pwo_pkg::PWO_PWM) && run_acc_q))
        else begin
            fail_count++;
            $error("rd_c_o enabled outside PWM with accumulate");
        end

endmodule

bind pwo_top pwo_checker u_checker (
    .clk          (clk),
    .reset_n      (reset_n),
    .enable_i     (enable_i),
    .mode_i       (mode_i),
    .accumulate_i (accumulate_i),
    .rd_a_i       (rd_a_o),
    .rd_b_i       (rd_b_o),
    .rd_c_i       (rd_c_o),
    .wr_i         (wr_o),
    .busy_i       (busy_o),
    .done_i       (done_o)
);

`default_nettype wire

/* verification/pwo_tb.sv */
// Directed testbench for the pointwise engine with behavioral operand memories
`timescale 1ns/1ps
`default_nettype none

`include "pwo_cfg.svh"

module pwo_tb;

    localparam int TIMEOUT   = 300;
    localparam int MEM_DEPTH = 2 ** `PWO_ADDR_W;
    localparam int Q         = `PWO_Q;

    localparam pwo_pkg::mem_addr_t BASE_A = 15'h0100;
    localparam pwo_pkg::mem_addr_t BASE_B = 15'h0200;
    localparam pwo_pkg::mem_addr_t BASE_C = 15'h0300;

    logic                  clk;
    logic                  reset_n;
    logic                  enable;
    pwo_pkg::pwo_mode_e    mode;
    logic                  accumulate;
    pwo_pkg::mem_addr_t    base_a;
    pwo_pkg::mem_addr_t    base_b;
    pwo_pkg::mem_addr_t    base_c;
    pwo_pkg::mem_word_t    rd_a_data;
    pwo_pkg::mem_word_t    rd_b_data;
    pwo_pkg::mem_word_t    rd_c_data;
    pwo_pkg::pwo_mem_req_t rd_a;
    pwo_pkg::pwo_mem_req_t rd_b;
    pwo_pkg::pwo_mem_req_t rd_c;
    pwo_pkg::pwo_mem_req_t wr;
    pwo_pkg::mem_word_t    wr_data;
    logic                  busy;
    logic                  done;

    pwo_pkg::mem_word_t mem_a [MEM_DEPTH];
    pwo_pkg::mem_word_t mem_b [MEM_DEPTH];
    pwo_pkg::mem_word_t mem_c [MEM_DEPTH];
    pwo_pkg::mem_word_t expected [`PWO_WORDS];

    integer             seed;
    int                 errors;
    int                 wr_count;
    int                 done_count;
    int                 c_rd_count;

    pwo_top UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .base_a_i     (base_a),
        .base_b_i     (base_b),
        .base_c_i     (base_c),
        .rd_a_data_i  (rd_a_data),
        .rd_b_data_i  (rd_b_data),
        .rd_c_data_i  (rd_c_data),
        .rd_a_o       (rd_a),
        .rd_b_o       (rd_b),
        .rd_c_o       (rd_c),
        .wr_o         (wr),
        .wr_data_o    (wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    always #4 clk = ~clk;

    //========================================
    // Compare tasks
    //========================================
    task automatic check_word(string name, pwo_pkg::mem_word_t exp, pwo_pkg::mem_word_t act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // Memories with one cycle read latency
    // Port c also takes the writes
    always @(posedge clk) begin
        if (rd_a.en) begin
            rd_a_data <= mem_a[rd_a.addr];
        end
        if (rd_b.en) begin
            rd_b_data <= mem_b[rd_b.addr];
        end
        if (rd_c.en) begin
            rd_c_data <= mem_c[rd_c.addr];
            c_rd_count++;
        end
        if (done) begin
            done_count++;
        end
        if (wr.en) begin
            check_count("wr_o.addr", int'(BASE_C) + wr_count, int'(wr.addr));
            if (wr_count < `PWO_WORDS) begin
                check_word("wr_data_o", expected[wr_count], wr_data);
            end
            mem_c[wr.addr] <= wr_data;
            wr_count++;
        end
    end

    //========================================
    // Reference model and stimulus
    //========================================
    function automatic pwo_pkg::coeff_t ref_lane(pwo_pkg::pwo_mode_e m, logic acc,
                                                 pwo_pkg::coeff_t a, pwo_pkg::coeff_t b,
                                                 pwo_pkg::coeff_t c);
        longint unsigned r;
        case (m)
            pwo_pkg::PWO_PWM: begin
                r = (64'(a) * 64'(b)) % 64'(Q);
                if (acc) begin
                    r = (r + 64'(c)) % 64'(Q);
                end
            end
            pwo_pkg::PWO_PWA: r = (64'(a) + 64'(b)) % 64'(Q);
            default:          r = (64'(a) + 64'(Q) - 64'(b)) % 64'(Q);
        endcase
        return pwo_pkg::coeff_t'(r);
    endfunction

    function automatic pwo_pkg::coeff_t rand_coeff();
        return pwo_pkg::coeff_t'($unsigned($random(seed)) % Q);
    endfunction

    // Word 0 carries the edge pairs (0,q-1) (q-1,q-1) (q-1,0) (0,0)
    task automatic fill_operands();
        pwo_pkg::mem_word_t wa;
        pwo_pkg::mem_word_t wb;
        pwo_pkg::mem_word_t wc;
        for (int w = 0; w < `PWO_WORDS; w++) begin
            wa = '0;
            wb = '0;
            wc = '0;
            for (int l = 0; l < `PWO_LANES; l++) begin
                wa.lane[l].coeff = rand_coeff();
                wb.lane[l].coeff = rand_coeff();
                wc.lane[l].coeff = rand_coeff();
                if (w == 0) begin
                    wa.lane[l].coeff = (l == 1 || l == 2) ? Q - 1 : 0;
                    wb.lane[l].coeff = (l < 2) ? Q - 1 : 0;
                    wc.lane[l].coeff = Q - 1;
                end
            end
            mem_a[BASE_A + pwo_pkg::mem_addr_t'(w)] = wa;
            mem_b[BASE_B + pwo_pkg::mem_addr_t'(w)] = wb;
            mem_c[BASE_C + pwo_pkg::mem_addr_t'(w)] = wc;
        end
    endtask

    task automatic build_expected(pwo_pkg::pwo_mode_e m, logic acc);
        pwo_pkg::mem_addr_t ofs;
        for (int w = 0; w < `PWO_WORDS; w++) begin
            ofs = pwo_pkg::mem_addr_t'(w);
            expected[w] = '0;
            for (int l = 0; l < `PWO_LANES; l++) begin
                expected[w].lane[l].coeff = ref_lane(m, acc, mem_a[BASE_A + ofs].lane[l].coeff,
                                                     mem_b[BASE_B + ofs].lane[l].coeff,
                                                     mem_c[BASE_C + ofs].lane[l].coeff);
            end
        end
    endtask

    task automatic start_run(pwo_pkg::pwo_mode_e m, logic acc);
        wr_count   = 0;
        done_count = 0;
        c_rd_count = 0;
        @(posedge clk);
        enable     <= 1'b1;
        mode       <= m;
        accumulate <= acc;
        base_a     <= BASE_A;
        base_b     <= BASE_B;
        base_c     <= BASE_C;
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Timeout: done_o did not pulse within %0d cycles", TIMEOUT);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic check_run_end(int exp_c_reads);
        check_count("write count", `PWO_WORDS, wr_count);
        check_count("done_o pulses", 1, done_count);
        check_count("rd_c_o reads", exp_c_reads, c_rd_count);
        check_bit("busy_o", 1'b0, busy);
    endtask

    //========================================
    // Tests
    //========================================
    task automatic test_reset();
        @(negedge clk);
        check_bit("busy_o", 1'b0, busy);
        check_bit("done_o", 1'b0, done);
        check_bit("rd_a_o.en", 1'b0, rd_a.en);
        check_bit("rd_b_o.en", 1'b0, rd_b.en);
        check_bit("rd_c_o.en", 1'b0, rd_c.en);
        check_bit("wr_o.en", 1'b0, wr.en);
    endtask

    task automatic test_pwm(logic acc);
        fill_operands();
        build_expected(pwo_pkg::PWO_PWM, acc);
        start_run(pwo_pkg::PWO_PWM, acc);
        wait_done();
        check_run_end(acc ? `PWO_WORDS : 0);
    endtask

    task automatic test_add_sub(pwo_pkg::pwo_mode_e m);
        fill_operands();
        build_expected(m, 1'b0);
        start_run(m, 1'b0);
        wait_done();
        check_run_end(0);
    endtask

    // Second pulse mid-run with a different setup must be ignored
    task automatic test_enable_while_busy();
        fill_operands();
        build_expected(pwo_pkg::PWO_PWM, 1'b0);
        start_run(pwo_pkg::PWO_PWM, 1'b0);
        repeat (10) @(posedge clk);
        enable     <= 1'b1;
        mode       <= pwo_pkg::PWO_PWA;
        accumulate <= 1'b1;
        base_a     <= 15'h1000;
        base_b     <= 15'h2000;
        base_c     <= 15'h3000;
        @(posedge clk);
        enable <= 1'b0;
        wait_done();
        check_run_end(0);
        repeat (8) @(negedge clk);
        check_bit("busy_o after run", 1'b0, busy);
        check_count("write count after run", `PWO_WORDS, wr_count);
    endtask

    initial begin
        seed       = 32'hdd82;
        errors     = 0;
        wr_count   = 0;
        done_count = 0;
        c_rd_count = 0;
        clk        = 1'b0;
        reset_n    = 1'b0;
        enable     = 1'b0;
        mode       = pwo_pkg::PWO_PWM;
        accumulate = 1'b0;
        base_a     = '0;
        base_b     = '0;
        base_c     = '0;
        rd_a_data  = '0;
        rd_b_data  = '0;
        rd_c_data  = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        test_reset();
        test_pwm(1'b0);
        test_pwm(1'b1);
        test_add_sub(pwo_pkg::PWO_PWA);
        test_add_sub(pwo_pkg::PWO_PWS);
        test_enable_while_busy();

        $display("Errors: %0d, assertion failures: %0d", errors, UUT.u_checker.fail_count);
        if (errors == 0 && UUT.u_checker.fail_count == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/pwo_addr_seq.sv */
// Word sequencer, issues operand reads and undelayed write requests over one polynomial
`timescale 1ns/1ps
`default_nettype none

`include "pwo_cfg.svh"

module pwo_addr_seq (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start_i,
    input  pwo_pkg::pwo_cfg_t     cfg_i,
    output pwo_pkg::pwo_mem_req_t rd_a_o,
    output pwo_pkg::pwo_mem_req_t rd_b_o,
    output pwo_pkg::pwo_mem_req_t rd_c_o,
    output pwo_pkg::pwo_mem_req_t wr_req_o,
    output logic                  last_o,
    output logic                  busy_o
);

    localparam int CNT_W   = $clog2(`PWO_WORDS);
    localparam int DRAIN_W = $clog2(`PWO_PIPE_LAT + 1);

    localparam logic [CNT_W-1:0]   LAST_WORD  = CNT_W'(`PWO_WORDS - 1);
    localparam logic [DRAIN_W-1:0] DRAIN_INIT = DRAIN_W'(`PWO_PIPE_LAT);

    logic               active_q;
    logic [CNT_W-1:0]   word_q;
    logic [DRAIN_W-1:0] drain_q;
    logic               c_rd_en;
    pwo_pkg::mem_addr_t word_ofs;

    //========================================
    // Word counter and drain
    //========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active_q <= 1'b0;
            word_q   <= '0;
            drain_q  <= '0;
        end
        else if (start_i) begin
            active_q <= 1'b1;
            word_q   <= '0;
        end
        else if (active_q) begin
            word_q <= word_q + 1'b1;
            if (word_q == LAST_WORD) begin
                active_q <= 1'b0;
                drain_q  <= DRAIN_INIT;
            end
        end
        else if (drain_q != '0) begin
            drain_q <= drain_q - 1'b1;
        end
    end

    assign word_ofs = pwo_pkg::mem_addr_t'(word_q);

    // Old c value is only needed for an accumulating multiply
    assign c_rd_en = active_q & cfg_i.accumulate & (cfg_i.mode == pwo_pkg::PWO_PWM);

    //========================================
    // Requests
    //========================================
    assign rd_a_o.en   = active_q;
    assign rd_a_o.addr = cfg_i.base_a + word_ofs;

    assign rd_b_o.en   = active_q;
    assign rd_b_o.addr = cfg_i.base_b + word_ofs;

    assign rd_c_o.en   = c_rd_en;
    assign rd_c_o.addr = cfg_i.base_c + word_ofs;

    // Delayed outside by the read plus ALU latency
    assign wr_req_o.en   = active_q;
    assign wr_req_o.addr = cfg_i.base_c + word_ofs;

    // First drain cycle, one cycle after word 63 was issued
    assign last_o = (drain_q == DRAIN_INIT);

    assign busy_o = active_q | (drain_q != '0);

endmodule

`default_nettype wire

/* verilog/pwo_delay_pipe.sv */
// Fixed-depth delay line for any payload type
`timescale 1ns/1ps
`default_nettype none

module pwo_delay_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset_n,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end
        else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

/* verilog/pwo_mod_alu.sv */
// Three-stage modular multiply, add and subtract for one coefficient lane
`timescale 1ns/1ps
`default_nettype none

`include "pwo_cfg.svh"

module pwo_mod_alu (
    input  logic               clk,
    input  logic               reset_n,
    input  pwo_pkg::pwo_mode_e op_i,
    input  logic               acc_i,
    input  pwo_pkg::coeff_t    a_i,
    input  pwo_pkg::coeff_t    b_i,
    input  pwo_pkg::coeff_t    c_i,
    output pwo_pkg::coeff_t    r_o
);

    localparam int CW     = `PWO_COEFF_W;
    localparam int SUM_W  = CW + 1;
    localparam int PROD_W = 2 * CW;
    // 2^23 == 2^13 - 1 mod q
    localparam int FOLD_SH = 13;

    localparam logic [SUM_W-1:0] Q_S = SUM_W'(`PWO_Q);

    logic [PROD_W-1:0] s1_d;
    logic [PROD_W-1:0] s1_q;
    logic [36:0]       fold1;
    logic [27:0]       fold2;
    logic [SUM_W-1:0]  fold3;
    logic [SUM_W-1:0]  s2_pre;
    logic [SUM_W-1:0]  s2_red;
    pwo_pkg::coeff_t   s2_q;
    pwo_pkg::coeff_t   c_d1_q;
    pwo_pkg::coeff_t   c_d2_q;
    pwo_pkg::coeff_t   addend;
    logic [SUM_W-1:0]  s3_sum;
    logic [SUM_W-1:0]  s3_red;
    pwo_pkg::coeff_t   r_q;

    //========================================
    // Stage 1: raw product, sum or difference
    //========================================
    always_comb begin
        case (op_i)
            pwo_pkg::PWO_PWM: s1_d = PROD_W'(a_i) * PROD_W'(b_i);
            // Adding q first keeps the difference positive
            pwo_pkg::PWO_PWS: s1_d = PROD_W'(a_i) + PROD_W'(`PWO_Q) - PROD_W'(b_i);
            default:          s1_d = PROD_W'(a_i) + PROD_W'(b_i);
        endcase
    end

    //========================================
    // Stage 2: fold and reduce
    //========================================
    // Each fold maps h*2^23 + l to h*(2^13 - 1) + l
    assign fold1 = (37'(s1_q[PROD_W-1:CW]) << FOLD_SH) - 37'(s1_q[PROD_W-1:CW])
                   + 37'(s1_q[CW-1:0]);
    assign fold2 = (28'(fold1[36:CW]) << FOLD_SH) - 28'(fold1[36:CW]) + 28'(fold1[CW-1:0]);
    // Below 2q after three folds
    assign fold3 = (SUM_W'(fold2[27:CW]) << FOLD_SH) - SUM_W'(fold2[27:CW])
                   + SUM_W'(fold2[CW-1:0]);

    assign s2_pre = (op_i == pwo_pkg::PWO_PWM) ? fold3 : s1_q[SUM_W-1:0];
    assign s2_red = (s2_pre >= Q_S) ? (s2_pre - Q_S) : s2_pre;

    //========================================
    // Stage 3: optional accumulate
    //========================================
    assign addend = (acc_i && (op_i == pwo_pkg::PWO_PWM)) ? c_d2_q : '0;
    assign s3_sum = {1'b0, s2_q} + {1'b0, addend};
    assign s3_red = (s3_sum >= Q_S) ? (s3_sum - Q_S) : s3_sum;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_q   <= '0;
            s2_q   <= '0;
            r_q    <= '0;
            c_d1_q <= '0;
            c_d2_q <= '0;
        end
        else begin
            s1_q   <= s1_d;
            s2_q   <= s2_red[CW-1:0];
            r_q    <= s3_red[CW-1:0];
            // c waits two stages to meet the reduced product
            c_d1_q <= c_i;
            c_d2_q <= c_d1_q;
        end
    end

    assign r_o = r_q;

endmodule

`default_nettype wire

/* verilog/pwo_mode_regs.sv */
// Configuration register block, latches the run setup and issues the start strobe
`timescale 1ns/1ps
`default_nettype none

module pwo_mode_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                enable_i,
    input  pwo_pkg::pwo_mode_e  mode_i,
    input  logic                accumulate_i,
    input  pwo_pkg::mem_addr_t  base_a_i,
    input  pwo_pkg::mem_addr_t  base_b_i,
    input  pwo_pkg::mem_addr_t  base_c_i,
    input  logic                busy_i,
    output pwo_pkg::pwo_cfg_t   cfg_o,
    output logic                start_o
);

    logic accept;

    // Busy only rises the cycle after start, so start itself also blocks a new enable
    assign accept = enable_i & ~busy_i & ~start_o;

    //========================================
    // Config capture
    //========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_o   <= '0;
            start_o <= 1'b0;
        end
        else begin
            start_o <= accept;
            // Held for the whole run, host inputs are free to move
            if (accept) begin
                cfg_o.mode       <= mode_i;
                cfg_o.accumulate <= accumulate_i;
                cfg_o.base_a     <= base_a_i;
                cfg_o.base_b     <= base_b_i;
                cfg_o.base_c     <= base_c_i;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pwo_pkg.sv */
// Shared types for the pointwise engine: modes, coefficients, memory words and requests
`default_nettype none

`include "pwo_cfg.svh"

package pwo_pkg;

    // Pointwise operation modes
    typedef enum logic [1:0] {
        PWO_PWM = 2'd0,
        PWO_PWA = 2'd1,
        PWO_PWS = 2'd2
    } pwo_mode_e;

    typedef logic [`PWO_COEFF_W-1:0] coeff_t;

    // One lane slot of a memory word
    typedef struct packed {
        logic [`PWO_LANE_W-`PWO_COEFF_W-1:0] pad;
        coeff_t                              coeff;
    } lane_t;

    // Lane 0 sits in the low bits
    typedef struct packed {
        lane_t [`PWO_LANES-1:0] lane;
    } mem_word_t;

    typedef logic [`PWO_ADDR_W-1:0] mem_addr_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } pwo_mem_req_t;

    typedef struct packed {
        pwo_mode_e mode;
        logic      accumulate;
        mem_addr_t base_a;
        mem_addr_t base_b;
        mem_addr_t base_c;
    } pwo_cfg_t;

endpackage

`default_nettype wire

/* verilog/pwo_top.sv */
// Pointwise engine top, connects config, sequencer, four ALU lanes and the delay lines
`timescale 1ns/1ps
`default_nettype none

`include "pwo_cfg.svh"

module pwo_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  pwo_pkg::pwo_mode_e    mode_i,
    input  logic                  accumulate_i,
    input  pwo_pkg::mem_addr_t    base_a_i,
    input  pwo_pkg::mem_addr_t    base_b_i,
    input  pwo_pkg::mem_addr_t    base_c_i,
    input  pwo_pkg::mem_word_t    rd_a_data_i,
    input  pwo_pkg::mem_word_t    rd_b_data_i,
    input  pwo_pkg::mem_word_t    rd_c_data_i,
    output pwo_pkg::pwo_mem_req_t rd_a_o,
    output pwo_pkg::pwo_mem_req_t rd_b_o,
    output pwo_pkg::pwo_mem_req_t rd_c_o,
    output pwo_pkg::pwo_mem_req_t wr_o,
    output pwo_pkg::mem_word_t    wr_data_o,
    output logic                  busy_o,
    output logic                  done_o
);

    pwo_pkg::pwo_cfg_t                      cfg;
    logic                                   start;
    pwo_pkg::pwo_mem_req_t                  wr_req;
    logic                                   last;
    pwo_pkg::coeff_t [`PWO_LANES-1:0]       alu_r;

    //========================================
    // Control
    //========================================
    pwo_mode_regs u_mode_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_a_i     (base_a_i),
        .base_b_i     (base_b_i),
        .base_c_i     (base_c_i),
        .busy_i       (busy_o),
        .cfg_o        (cfg),
        .start_o      (start)
    );

    pwo_addr_seq u_addr_seq (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start),
        .cfg_i    (cfg),
        .rd_a_o   (rd_a_o),
        .rd_b_o   (rd_b_o),
        .rd_c_o   (rd_c_o),
        .wr_req_o (wr_req),
        .last_o   (last),
        .busy_o   (busy_o)
    );

    // Write request and done follow the data through read latency plus ALU
    pwo_delay_pipe #(
        .payload_t (pwo_pkg::pwo_mem_req_t),
        .DEPTH     (`PWO_PIPE_LAT)
    ) u_wr_pipe (
        .clk     (clk),
        .reset_n (reset_n),
        .d_i     (wr_req),
        .q_o     (wr_o)
    );

    pwo_delay_pipe #(
        .payload_t (logic),
        .DEPTH     (`PWO_PIPE_LAT)
    ) u_done_pipe (
        .clk     (clk),
        .reset_n (reset_n),
        .d_i     (last),
        .q_o     (done_o)
    );

    //========================================
    // Datapath lanes
    //========================================
    for (genvar g = 0; g < `PWO_LANES; g++) begin : g_lane
        pwo_mod_alu u_alu (
            .clk     (clk),
            .reset_n (reset_n),
            .op_i    (cfg.mode),
            .acc_i   (cfg.accumulate),
            .a_i     (rd_a_data_i.lane[g].coeff),
            .b_i     (rd_b_data_i.lane[g].coeff),
            .c_i     (rd_c_data_i.lane[g].coeff),
            .r_o     (alu_r[g])
        );
    end

    // Repack results with zero pad bits
    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            wr_data_o.lane[i].pad   = '0;
            wr_data_o.lane[i].coeff = alu_r[i];
        end
    end

endmodule

`default_nettype wire
